//--- verilog.f
+incdir+hdl
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/insn_decoder.sv
hdl/execute_unit.sv
hdl/register_file.sv
hdl/result_unit.sv
hdl/core_top.sv
verification/core_tb_memory.sv
verification/core_tb.sv

//--- Makefile
VERILATOR := verilator
TOP       := core_tb
FILE_LIST := verilog.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- verification/core_tb.sv
// Core testbench with program generation, a store model and bus protocol checks
`default_nettype none

`include "core_config.svh"

module core_tb;

    import core_pkg::*;

    localparam int         CLK_PERIOD      = 40;
    localparam int         RESET_CYCLES    = 10;
    localparam int         SEED            = 31;
    localparam int         CODE_WORDS      = 1024;
    localparam int         CYCLES_PER_INSN = 200;
    // Cycles watched after halt for stray stores
    localparam int         DRAIN_CYCLES    = 20;
    localparam logic [7:0] NOP_BYTE        = 8'h90;

    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] data;
    } store_t;

    logic                        clk;
    logic                        rst;
    wb_req_t                     instr_wb;
    logic [`CORE_DATA_WIDTH-1:0] instr_dat;
    logic                        instr_ack;
    wb_req_t                     data_wb;
    logic                        data_ack;
    logic                        halted;

    logic [7:0]  prog [$];
    store_t      exp_q [$];
    logic [15:0] model_regs [`CORE_NUM_REGS];
    logic        model_zf;
    int          insn_count;
    logic        prog_ready;
    store_t      got;
    wb_req_t     instr_last;
    wb_req_t     data_last;
    logic        instr_held;
    logic        instr_acked;
    logic        data_held;
    logic        data_acked;

    core_top core_top_inst (
        .clk(clk),
        .rst(rst),
        .instr_wb(instr_wb),
        .instr_dat(instr_dat),
        .instr_ack(instr_ack),
        .data_wb(data_wb),
        .data_ack(data_ack),
        .halted(halted)
    );

    core_tb_memory #(.CODE_WORDS(CODE_WORDS)) memory_inst (
        .clk(clk),
        .instr_wb(instr_wb),
        .instr_dat(instr_dat),
        .instr_ack(instr_ack),
        .data_wb(data_wb),
        .data_ack(data_ack)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    function automatic logic [15:0] random_word();
        logic [31:0] r;
        r = $urandom;
        return r[15:0];
    endfunction

    function automatic reg_idx_t pick_reg(input int unsigned lo);
        logic [31:0] r;
        r = $urandom_range(7, lo);
        return r[2:0];
    endfunction

    function automatic logic [15:0] even_addr();
        return random_word() & 16'hFFFE;
    endfunction

    // ADD, SUB, AND, OR, XOR in the r/m16,r16 form
    function automatic logic [7:0] opcode_byte(input int k);
        case (k)
            0:       return 8'h01;
            1:       return 8'h29;
            2:       return 8'h21;
            3:       return 8'h09;
            default: return 8'h31;
        endcase
    endfunction

    function automatic logic [15:0] model_result(input int k, input logic [15:0] a,
                                                 input logic [15:0] b);
        case (k)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic mov_imm(input reg_idx_t r, input logic [15:0] v);
        prog.push_back({5'b10111, r});
        prog.push_back(v[7:0]);
        prog.push_back(v[15:8]);
        model_regs[r] = v;
        insn_count++;
    endtask

    task automatic alu_insn(input int k, input reg_idx_t dst, input reg_idx_t src);
        prog.push_back(opcode_byte(k));
        prog.push_back({2'b11, src, dst});
        model_regs[dst] = model_result(k, model_regs[dst], model_regs[src]);
        model_zf        = model_regs[dst] == 16'h0000;
        insn_count++;
    endtask

    task automatic store_ax(input logic [15:0] addr, input logic skipped);
        store_t s;
        prog.push_back(8'hA3);
        prog.push_back(addr[7:0]);
        prog.push_back(addr[15:8]);
        s.addr = addr;
        s.data = model_regs[0];
        if (!skipped) begin
            exp_q.push_back(s);
        end
        insn_count++;
    endtask

    task automatic jump_over_store(input logic jnz, input logic [15:0] addr);
        logic taken;
        taken = jnz ? !model_zf : model_zf;
        prog.push_back(jnz ? 8'h75 : 8'h74);
        // rel8 spans the three-byte store
        prog.push_back(8'h03);
        insn_count++;
        store_ax(addr, taken);
    endtask

    task automatic pad_nop();
        prog.push_back(NOP_BYTE);
        insn_count++;
    endtask

    task automatic build_program();
        reg_idx_t    dst;
        reg_idx_t    src;
        logic [15:0] a;
        logic [15:0] b;
        insn_count = 0;
        model_zf   = 1'b0;
        for (int r = 0; r < `CORE_NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < 6; i++) begin
            mov_imm(3'd0, random_word());
            store_ax(even_addr(), 1'b0);
        end
        // Result reaches AX through OR into a cleared AX
        for (int i = 0; i < 30; i++) begin
            dst = pick_reg(1);
            src = pick_reg(0);
            mov_imm(dst, random_word());
            mov_imm(src, random_word());
            alu_insn(i % 5, dst, src);
            mov_imm(3'd0, 16'h0000);
            alu_insn(3, 3'd0, dst);
            store_ax(even_addr(), 1'b0);
        end
        // Equal operands for patterns 0 and 3, JNZ for patterns 2 and 3
        for (int i = 0; i < 16; i++) begin
            a = random_word();
            b = (i % 4 == 0 || i % 4 == 3) ? a : a ^ (random_word() | 16'h0001);
            pad_nop();
            mov_imm(3'd1, a);
            mov_imm(3'd2, b);
            alu_insn(1, 3'd1, 3'd2);
            mov_imm(3'd0, random_word());
            jump_over_store(i % 4 >= 2, even_addr());
        end
        prog.push_back(8'hF4);
        insn_count++;
    endtask

    task automatic load_program();
        logic [7:0] lo;
        logic [7:0] hi;
        for (int w = 0; w < CODE_WORDS; w++) begin
            lo = (2 * w < prog.size()) ? prog[2 * w] : NOP_BYTE;
            hi = (2 * w + 1 < prog.size()) ? prog[2 * w + 1] : NOP_BYTE;
            memory_inst.code[w] = {hi, lo};
        end
    endtask

    task automatic check_request(input string bus, input wb_req_t now, input wb_req_t last,
                                 input logic held, input logic acked);
        assert (now.cyc == now.stb)
            else report_failure({bus, " bus has cyc and stb at different levels"});
        if (held) begin
            assert (now.stb && now.adr == last.adr && now.dat == last.dat
                    && now.we == last.we && now.sel == last.sel)
                else report_failure({bus, " bus request changed before ack"});
        end
        if (acked) begin
            assert (!now.stb) else report_failure({bus, " bus kept stb high after ack"});
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst) begin
            instr_held  = 1'b0;
            instr_acked = 1'b0;
            data_held   = 1'b0;
            data_acked  = 1'b0;
        end else begin
            check_request("Instruction", instr_wb, instr_last, instr_held, instr_acked);
            check_request("Data", data_wb, data_last, data_held, data_acked);
            instr_held  = instr_wb.stb && !instr_ack;
            instr_acked = instr_wb.stb && instr_ack;
            instr_last  = instr_wb;
            data_held   = data_wb.stb && !data_ack;
            data_acked  = data_wb.stb && data_ack;
            data_last   = data_wb;
        end
    end

    // Each acked data cycle is one store, checked against the model in order
    always @(posedge clk) begin
        if (!rst && data_wb.cyc && data_wb.stb && data_ack) begin
            assert (data_wb.we && data_wb.sel == 2'b11
                    && data_wb.adr[`CORE_ADDR_WIDTH:`CORE_DATA_WIDTH] == '0)
                else report_failure("Data cycle is not a full word store in the low 64K");
            assert (exp_q.size() > 0) else report_failure("Store happened with none expected");
            got.addr = {data_wb.adr[15:1], 1'b0};
            got.data = data_wb.dat;
            assert (got == exp_q[0])
                else report_failure($sformatf("ERROR %0t: store of %h to %h, expected %h to %h",
                    $time, got.data, got.addr, exp_q[0].data, exp_q[0].addr));
            void'(exp_q.pop_front());
        end
    end

    initial begin
        wait (prog_ready === 1'b1);
        #(CLK_PERIOD * (RESET_CYCLES + CYCLES_PER_INSN * insn_count));
        report_failure($sformatf("Timeout, core did not halt within %0d cycles",
            RESET_CYCLES + CYCLES_PER_INSN * insn_count));
    end

    initial begin
        void'($urandom(SEED));
        rst        = 1'b1;
        prog_ready = 1'b0;
        build_program();
        load_program();
        prog_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        assert (!halted && !instr_wb.cyc && !data_wb.cyc)
            else report_failure("Core is not idle at the end of reset");
        rst = 1'b0;
        while (!halted) begin
            @(negedge clk);
        end
        assert (exp_q.size() == 0) else report_failure("Core halted with stores outstanding");
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            assert (!data_wb.cyc) else report_failure("Data bus cycle started after halt");
        end
        if (exp_q.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            report_failure($sformatf("%0d expected stores never happened", exp_q.size()));
        end
    end

endmodule

`default_nettype wire

//--- verification/core_tb_memory.sv
// Code memory and data-bus slave, both acking after random wait states
`default_nettype none

module core_tb_memory #(
    parameter int CODE_WORDS = 1024
) (
    input  logic              clk,
    input  core_pkg::wb_req_t instr_wb,
    output logic [15:0]       instr_dat,
    output logic              instr_ack,
    input  core_pkg::wb_req_t data_wb,
    output logic              data_ack
);

    localparam int INDEX_MSB = $clog2(CODE_WORDS);

    // Filled by the testbench before reset is released
    logic [15:0] code [CODE_WORDS];
    int unsigned instr_wait;
    int unsigned data_wait;

    initial begin
        instr_ack  = 1'b0;
        instr_dat  = '0;
        instr_wait = 0;
        forever begin
            @(negedge clk);
            if (instr_wb.cyc && instr_wb.stb && !instr_ack) begin
                if (instr_wait == 0) begin
                    instr_dat = code[instr_wb.adr[INDEX_MSB:1]];
                    instr_ack = 1'b1;
                end else begin
                    instr_wait--;
                end
            end else begin
                // Wait states for the next cycle
                instr_ack  = 1'b0;
                instr_wait = $urandom_range(3, 0);
            end
        end
    end

    initial begin
        data_ack  = 1'b0;
        data_wait = 0;
        forever begin
            @(negedge clk);
            if (data_wb.cyc && data_wb.stb && !data_ack) begin
                if (data_wait == 0) begin
                    data_ack = 1'b1;
                end else begin
                    data_wait--;
                end
            end else begin
                data_ack  = 1'b0;
                data_wait = $urandom_range(3, 0);
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/core_top.sv
// Core top level connecting fetch, decode, execute, register file and result stages
`default_nettype none

`include "core_config.svh"

module core_top (
    input  logic                        clk,
    input  logic                        rst,
    output core_pkg::wb_req_t           instr_wb,
    input  logic [`CORE_DATA_WIDTH-1:0] instr_dat,
    input  logic                        instr_ack,
    output core_pkg::wb_req_t           data_wb,
    input  logic                        data_ack,
    output logic                        halted
);

    import core_pkg::*;

    logic                        byte_valid;
    logic [7:0]                  byte_data;
    logic [`CORE_DATA_WIDTH-1:0] byte_addr;
    logic                        byte_ready;
    logic                        insn_valid;
    insn_t                       insn;
    logic                        insn_ready;
    reg_idx_t                    rd_sel_a;
    reg_idx_t                    rd_sel_b;
    logic [`CORE_DATA_WIDTH-1:0] rd_val_a;
    logic [`CORE_DATA_WIDTH-1:0] rd_val_b;
    flags_t                      flags;
    logic                        result_valid;
    result_t                     result;
    logic                        result_ready;
    logic                        redirect;
    logic [`CORE_DATA_WIDTH-1:0] redirect_ip;
    logic                        wr_en;
    reg_idx_t                    wr_sel;
    logic [`CORE_DATA_WIDTH-1:0] wr_val;

    fetch_unit fetch_unit_inst (.*);

    // A redirect empties the decoder
    insn_decoder insn_decoder_inst (
        .flush(redirect),
        .*
    );

    execute_unit execute_unit_inst (.*);

    register_file register_file_inst (.*);

    result_unit result_unit_inst (.*);

endmodule

`default_nettype wire

//--- hdl/result_unit.sv
// Result unit for register and flag write-back, and the data-bus store master
`default_nettype none

`include "core_config.svh"

module result_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        result_valid,
    input  core_pkg::result_t           result,
    output logic                        result_ready,
    output logic                        wr_en,
    output core_pkg::reg_idx_t          wr_sel,
    output logic [`CORE_DATA_WIDTH-1:0] wr_val,
    output core_pkg::flags_t            flags,
    output core_pkg::wb_req_t           data_wb,
    input  logic                        data_ack
);

    typedef enum logic {
        ST_IDLE,
        ST_STORE
    } state_e;

    state_e                      state;
    logic                        take;
    logic [`CORE_DATA_WIDTH-2:0] store_word;
    logic [`CORE_DATA_WIDTH-1:0] store_dat;

    assign result_ready = state == ST_IDLE;
    assign take         = result_valid && result_ready;

    // Register write lands on the acceptance edge
    assign wr_en  = take && result.reg_wr;
    assign wr_sel = result.dst;
    assign wr_val = result.value;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            flags <= '0;
        end else begin
            case (state)
                ST_IDLE:  state <= (take && result.store) ? ST_STORE : ST_IDLE;
                ST_STORE: state <= data_ack ? ST_IDLE : ST_STORE;
            endcase
            if (take && result.flags_wr) begin
                flags <= result.flags;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && result.store) begin
            store_word <= result.store_addr[`CORE_DATA_WIDTH-1:1];
            store_dat  <= result.value;
        end
    end

    // Word store with both byte lanes, upper address bits zero
    always_comb begin
        data_wb     = '0;
        data_wb.cyc = state == ST_STORE;
        data_wb.stb = state == ST_STORE;
        data_wb.we  = state == ST_STORE;
        data_wb.adr = {{(`CORE_ADDR_WIDTH - `CORE_DATA_WIDTH + 1){1'b0}}, store_word};
        data_wb.dat = store_dat;
        data_wb.sel = 2'b11;
    end

endmodule

`default_nettype wire

//--- hdl/register_file.sv
// Register file of eight 16-bit general registers with two read ports and one write port
`default_nettype none

`include "core_config.svh"

module register_file (
    input  logic                        clk,
    input  logic                        rst,
    input  core_pkg::reg_idx_t          rd_sel_a,
    input  core_pkg::reg_idx_t          rd_sel_b,
    output logic [`CORE_DATA_WIDTH-1:0] rd_val_a,
    output logic [`CORE_DATA_WIDTH-1:0] rd_val_b,
    input  logic                        wr_en,
    input  core_pkg::reg_idx_t          wr_sel,
    input  logic [`CORE_DATA_WIDTH-1:0] wr_val
);

    logic [`CORE_DATA_WIDTH-1:0] regs [`CORE_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_sel] <= wr_val;
        end
    end

    assign rd_val_a = regs[rd_sel_a];
    assign rd_val_b = regs[rd_sel_b];

endmodule

`default_nettype wire

//--- hdl/execute_unit.sv
// Execute unit with the ALU and jump test, producing one result per instruction
`default_nettype none

`include "core_config.svh"

module execute_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        insn_valid,
    input  core_pkg::insn_t             insn,
    output logic                        insn_ready,
    output core_pkg::reg_idx_t          rd_sel_a,
    output core_pkg::reg_idx_t          rd_sel_b,
    input  logic [`CORE_DATA_WIDTH-1:0] rd_val_a,
    input  logic [`CORE_DATA_WIDTH-1:0] rd_val_b,
    input  core_pkg::flags_t            flags,
    output logic                        result_valid,
    output core_pkg::result_t           result,
    input  logic                        result_ready,
    output logic                        redirect,
    output logic [`CORE_DATA_WIDTH-1:0] redirect_ip,
    output logic                        halted
);

    import core_pkg::*;

    logic                      take;
    logic                      taken;
    logic                      produces;
    logic                      hlt_seen;
    logic [`CORE_DATA_WIDTH:0] sum;
    logic [`CORE_DATA_WIDTH:0] diff;
    result_t                   res_next;

    // Hold off during a redirect so no wrong-path instruction slips in
    assign insn_ready = !result_valid && !hlt_seen && !redirect;
    assign take       = insn_valid && insn_ready;

    assign rd_sel_a = insn.dst;
    assign rd_sel_b = insn.src;

    assign sum   = {1'b0, rd_val_a} + {1'b0, rd_val_b};
    assign diff  = {1'b0, rd_val_a} - {1'b0, rd_val_b};
    assign taken = (insn.op == OP_JZ && flags.zf) || (insn.op == OP_JNZ && !flags.zf);

    always_comb begin
        res_next            = '0;
        res_next.dst        = insn.dst;
        res_next.store_addr = insn.imm;
        res_next.reg_wr     = 1'b1;
        res_next.flags_wr   = 1'b1;
        case (insn.op)
            OP_ADD: begin
                res_next.value    = sum[`CORE_DATA_WIDTH-1:0];
                res_next.flags.cf = sum[`CORE_DATA_WIDTH];
            end
            OP_SUB: begin
                res_next.value    = diff[`CORE_DATA_WIDTH-1:0];
                res_next.flags.cf = diff[`CORE_DATA_WIDTH];
            end
            OP_AND: res_next.value = rd_val_a & rd_val_b;
            OP_OR:  res_next.value = rd_val_a | rd_val_b;
            OP_XOR: res_next.value = rd_val_a ^ rd_val_b;
            OP_MOV_IMM: begin
                res_next.value    = insn.imm;
                res_next.flags_wr = 1'b0;
            end
            OP_STORE: begin
                res_next.value    = rd_val_a;
                res_next.reg_wr   = 1'b0;
                res_next.flags_wr = 1'b0;
                res_next.store    = 1'b1;
            end
            default: begin
                res_next.reg_wr   = 1'b0;
                res_next.flags_wr = 1'b0;
            end
        endcase
        res_next.flags.zf = res_next.value == '0;
        res_next.flags.sf = res_next.value[`CORE_DATA_WIDTH-1];
    end

    // Jumps, HLT and no-ops leave nothing for the result stage
    assign produces = res_next.reg_wr || res_next.store;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            redirect     <= 1'b0;
            hlt_seen     <= 1'b0;
            halted       <= 1'b0;
        end else begin
            if (result_valid) begin
                result_valid <= !result_ready;
            end else begin
                result_valid <= take && produces;
            end
            redirect <= take && taken;
            if (take && insn.op == OP_HLT) begin
                hlt_seen <= 1'b1;
            end
            // Wait for an open store to drain before reporting halt
            if (hlt_seen && !result_valid && result_ready) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            result      <= res_next;
            redirect_ip <= insn.next_ip + insn.imm;
        end
    end

endmodule

`default_nettype wire

//--- hdl/insn_decoder.sv
// Instruction decoder that assembles one decoded instruction from the code byte stream
`default_nettype none

`include "core_config.svh"

module insn_decoder (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        byte_valid,
    input  logic [7:0]                  byte_data,
    input  logic [`CORE_DATA_WIDTH-1:0] byte_addr,
    output logic                        byte_ready,
    input  logic                        flush,
    output logic                        insn_valid,
    output core_pkg::insn_t             insn,
    input  logic                        insn_ready
);

    import core_pkg::*;

    typedef enum logic [2:0] {
        ST_OPCODE,
        ST_MODRM,
        ST_IMM_LO,
        ST_IMM_HI,
        ST_REL8,
        ST_DONE
    } state_e;

    state_e  state;
    state_e  op_state;
    opcode_e op_decoded;
    logic    take;

    assign byte_ready = state != ST_DONE;
    assign insn_valid = state == ST_DONE;
    assign take       = byte_valid && byte_ready && !flush;

    always_comb begin
        case (byte_data)
            8'h01:   op_decoded = OP_ADD;
            8'h29:   op_decoded = OP_SUB;
            8'h21:   op_decoded = OP_AND;
            8'h09:   op_decoded = OP_OR;
            8'h31:   op_decoded = OP_XOR;
            8'hA3:   op_decoded = OP_STORE;
            8'h74:   op_decoded = OP_JZ;
            8'h75:   op_decoded = OP_JNZ;
            8'hF4:   op_decoded = OP_HLT;
            default: op_decoded = (byte_data[7:3] == 5'b10111) ? OP_MOV_IMM : OP_NOP;
        endcase

        // Bytes still to come after the opcode
        case (op_decoded)
            OP_MOV_IMM, OP_STORE:                  op_state = ST_IMM_LO;
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: op_state = ST_MODRM;
            OP_JZ, OP_JNZ:                         op_state = ST_REL8;
            default:                               op_state = ST_DONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= ST_OPCODE;
        end else if (state == ST_DONE) begin
            if (insn_ready) begin
                state <= ST_OPCODE;
            end
        end else if (take) begin
            case (state)
                ST_OPCODE: state <= op_state;
                ST_IMM_LO: state <= ST_IMM_HI;
                default:   state <= ST_DONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            // Last byte taken leaves the address after the instruction
            insn.next_ip <= byte_addr + 1'b1;
            case (state)
                ST_OPCODE: begin
                    insn.op  <= op_decoded;
                    // Store always takes its data from AX
                    insn.dst <= (op_decoded == OP_STORE) ? 3'd0 : byte_data[2:0];
                    insn.src <= 3'd0;
                end
                ST_MODRM: begin
                    insn.dst <= byte_data[2:0];
                    insn.src <= byte_data[5:3];
                end
                ST_IMM_LO: insn.imm[7:0] <= byte_data;
                ST_IMM_HI: insn.imm[`CORE_DATA_WIDTH-1:8] <= byte_data;
                ST_REL8:   insn.imm <= {{(`CORE_DATA_WIDTH - 8){byte_data[7]}}, byte_data};
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
// Fetch unit, an instruction-bus Wishbone master that tracks the IP and hands out code bytes
`default_nettype none

`include "core_config.svh"

module fetch_unit (
    input  logic                        clk,
    input  logic                        rst,
    output core_pkg::wb_req_t           instr_wb,
    input  logic [`CORE_DATA_WIDTH-1:0] instr_dat,
    input  logic                        instr_ack,
    output logic                        byte_valid,
    output logic [7:0]                  byte_data,
    output logic [`CORE_DATA_WIDTH-1:0] byte_addr,
    input  logic                        byte_ready,
    input  logic                        redirect,
    input  logic [`CORE_DATA_WIDTH-1:0] redirect_ip
);

    // IP is the address of the buffered byte, or of the byte being fetched
    logic [`CORE_DATA_WIDTH-1:0] ip;
    logic [`CORE_DATA_WIDTH-1:0] ip_next;
    logic [`CORE_DATA_WIDTH-2:0] fetch_word;
    logic                        cyc;
    logic                        discard;
    logic                        buf_valid;
    logic [7:0]                  buf_data;
    logic                        accept;
    logic                        start;
    logic                        load;

    assign accept  = buf_valid && byte_ready;
    assign ip_next = redirect ? redirect_ip : (accept ? ip + 1'b1 : ip);

    // Open a cycle once the buffer is empty or emptying this cycle
    assign start = !cyc && (!buf_valid || accept || redirect);
    assign load  = cyc && instr_ack && !discard && !redirect;

    always_ff @(posedge clk) begin
        if (rst) begin
            ip        <= `CORE_RESET_IP;
            cyc       <= 1'b0;
            discard   <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            ip <= ip_next;

            if (start) begin
                cyc <= 1'b1;
            end else if (instr_ack) begin
                cyc <= 1'b0;
            end

            // Cycle in flight at a redirect still finishes, its data is dropped
            if (cyc && instr_ack) begin
                discard <= 1'b0;
            end else if (cyc && redirect) begin
                discard <= 1'b1;
            end

            if (load) begin
                buf_valid <= 1'b1;
            end else if (accept || redirect) begin
                buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            fetch_word <= ip_next[`CORE_DATA_WIDTH-1:1];
        end
        if (load) begin
            buf_data <= ip[0] ? instr_dat[`CORE_DATA_WIDTH-1:8] : instr_dat[7:0];
        end
    end

    assign byte_valid = buf_valid;
    assign byte_data  = buf_data;
    assign byte_addr  = ip;

    // Read-only master, code segment fixed at zero
    always_comb begin
        instr_wb     = '0;
        instr_wb.cyc = cyc;
        instr_wb.stb = cyc;
        instr_wb.adr = {{(`CORE_ADDR_WIDTH - `CORE_DATA_WIDTH + 1){1'b0}}, fetch_word};
        instr_wb.sel = 2'b11;
    end

endmodule

`default_nettype wire

//--- hdl/core_pkg.sv
// Core package with opcode, instruction, result, flags and Wishbone request types
`default_nettype none

`include "core_config.svh"

package core_pkg;

    typedef enum logic [3:0] {
        OP_MOV_IMM,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_STORE,
        OP_JZ,
        OP_JNZ,
        OP_HLT,
        OP_NOP
    } opcode_e;

    // AX=0, CX, DX, BX, SP, BP, SI, DI=7
    typedef logic [2:0] reg_idx_t;

    typedef struct packed {
        opcode_e                     op;
        reg_idx_t                    dst;
        reg_idx_t                    src;
        logic [`CORE_DATA_WIDTH-1:0] imm;
        logic [`CORE_DATA_WIDTH-1:0] next_ip;
    } insn_t;

    typedef struct packed {
        logic zf;
        logic sf;
        logic cf;
    } flags_t;

    typedef struct packed {
        logic                        reg_wr;
        reg_idx_t                    dst;
        logic [`CORE_DATA_WIDTH-1:0] value;
        logic                        flags_wr;
        flags_t                      flags;
        logic                        store;
        logic [`CORE_DATA_WIDTH-1:0] store_addr;
    } result_t;

    // Master side of a Wishbone classic bus
    typedef struct packed {
        logic                        cyc;
        logic                        stb;
        logic                        we;
        logic [`CORE_ADDR_WIDTH:1]   adr;
        logic [`CORE_DATA_WIDTH-1:0] dat;
        logic [1:0]                  sel;
    } wb_req_t;

endpackage

`default_nettype wire

//--- hdl/core_config.svh
// Core configuration macros for bus widths, register count and reset IP
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Word address on both buses covers bits 19:1
`define CORE_ADDR_WIDTH 19

// Bus and register width
`define CORE_DATA_WIDTH 16

// General registers AX through DI
`define CORE_NUM_REGS 8

`define CORE_RESET_IP 16'h0000

`endif
